// ==== dv/tb_rvv_retire.sv ====
`include "rt_config.svh"

module tb_rvv_retire;

  import rt_uop_pkg::*;
  import rt_wb_pkg::*;

  localparam int NU = `RT_NUM_UOP;
  localparam int VB = `RT_VLENB;
  localparam int VLEN = `RT_VLEN;
  localparam int XLEN = `RT_XLEN;
  localparam int IW = `RT_INDEX_W;
  localparam int CW = `RT_VLEN;  // widest value an error line shows
  localparam int PERIOD = 100;
  localparam int RESET_CYCLES = 8;
  localparam int TEST_CYCLES = 2000;
  localparam int WATCHDOG_TIME = (RESET_CYCLES + TEST_CYCLES + 20) * PERIOD;

  logic                   clk;
  logic                   reset;
  logic [NU-1:0]          rob_valid;
  rob2rt_t [NU-1:0]       rob_data;
  logic [NU-1:0]          vrf_valid;
  rt2vrf_t [NU-1:0]       vrf_data;
  logic [NU-1:0]          xrf_valid;
  rt2xrf_t [NU-1:0]       xrf_data;
  logic                   vcsr_valid;
  vcsr_t                  vcsr_data;
  logic                   vxsat_set;

  // reference outputs, same one-cycle latency as the DUT
  logic [NU-1:0]          exp_vrf_valid;
  logic [NU-1:0]          exp_xrf_valid;
  rt2vrf_t [NU-1:0]       exp_vrf_data;
  rt2xrf_t [NU-1:0]       exp_xrf_data;
  logic                   exp_vcsr_valid;
  vcsr_t                  exp_vcsr_data;
  logic                   exp_vxsat;

  int                     error_count;

  rvv_retire uut (
    .clk        (clk),
    .reset      (reset),
    .rob_valid  (rob_valid),
    .rob_data   (rob_data),
    .vrf_valid  (vrf_valid),
    .vrf_data   (vrf_data),
    .xrf_valid  (xrf_valid),
    .xrf_data   (xrf_data),
    .vcsr_valid (vcsr_valid),
    .vcsr_data  (vcsr_data),
    .vxsat_set  (vxsat_set)
  );

  always #(PERIOD / 2) clk = ~clk;

  ////////////////////
  // error reporting

  task automatic raise_error(input string what);
    error_count++;
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "run stopped");
  endtask

  task automatic value_mismatch(input string name, input logic [CW-1:0] got,
                                input logic [CW-1:0] want);
    raise_error($sformatf("CHECK FAILED at time %0t: %s got 0x%0h expected 0x%0h",
                          $time, name, got, want));
  endtask

  ////////////////////
  // random groups

  // three registers only, so index matches are common
  function automatic logic [IW-1:0] pick_index();
    case ($urandom % 3)
      0:       return IW'(3);
      1:       return IW'(17);
      default: return IW'(30);
    endcase
  endfunction

  function automatic rob2rt_t random_uop(input logic w_type);
    rob2rt_t u;
    u.w_valid = ($urandom % 8) != 0;
    u.w_type  = w_type;
    u.w_index = pick_index();
    for (int w = 0; w < VLEN / 32; w++) begin
      u.w_data[w*32 +: 32] = $urandom;
    end
    for (int b = 0; b < VB; b++) begin
      // half the bytes body active, rest spread over the other tags
      u.vd_type[b]   = (($urandom % 2) != 0) ? BODY_ACTIVE : byte_type_e'(2'($urandom % 3));
      u.vsaturate[b] = ($urandom % 4) == 0;
    end
    u.trap_flag         = ($urandom % 8) == 0;
    u.vector_csr.vl     = 16'($urandom);
    u.vector_csr.vstart = 16'($urandom);
    u.vector_csr.vlmul  = 3'($urandom);
    u.vector_csr.vsew   = 3'($urandom);
    u.vector_csr.vma    = 1'($urandom);
    u.vector_csr.vta    = 1'($urandom);
    return u;
  endfunction

  task automatic make_group(output logic [NU-1:0] v, output rob2rt_t [NU-1:0] d);
    logic type_now;
    type_now = ($urandom % 2) == 1;
    for (int k = 0; k < NU; k++) begin
      if (k > 0 && ($urandom % 4) == 0) begin
        type_now = !type_now;  // breaks the run now and then
      end
      v[k] = ($urandom % 10) != 0;
      d[k] = random_uop(type_now);
    end
  endtask

  ////////////////////
  // reference model

  function automatic logic [VB-1:0] active_bytes(input rob2rt_t u);
    logic [VB-1:0] act;
    for (int b = 0; b < VB; b++) begin
      act[b] = (u.vd_type[b] == BODY_ACTIVE);
    end
    return act;
  endfunction

  always @(posedge clk) begin : ref_model
    logic [VB-1:0]    act [NU];
    int               run_end;
    logic [NU-1:0]    killed;
    logic [NU-1:0]    live;
    logic             csr_found;
    vcsr_t            csr_pick;
    logic             sat;
    rt2vrf_t [NU-1:0] vrf_e;
    rt2xrf_t [NU-1:0] xrf_e;

    for (int k = 0; k < NU; k++) begin
      act[k] = active_bytes(rob_data[k]);
    end

    // run is lanes 0..run_end
    run_end = 0;
    while (run_end < NU - 1 &&
           rob_valid[run_end + 1] == rob_valid[run_end] &&
           rob_data[run_end + 1].w_type == rob_data[run_end].w_type) begin
      run_end++;
    end

    for (int k = 0; k < NU; k++) begin
      killed[k] = 1'b0;
      for (int j = 0; j < k; j++) begin
        if (rob_data[j].trap_flag) begin
          killed[k] = 1'b1;
        end
      end
      live[k] = rob_data[k].w_valid && !killed[k];
    end

    for (int k = 0; k < NU; k++) begin
      vrf_e[k].rt_index  = rob_data[k].w_index;
      vrf_e[k].rt_data   = rob_data[k].w_data;
      vrf_e[k].rt_strobe = act[k];
      for (int j = k + 1; j <= run_end; j++) begin
        if (rob_data[j].w_index == rob_data[k].w_index) begin
          vrf_e[k].rt_strobe = vrf_e[k].rt_strobe & ~act[j];  // younger lane wins
        end
      end
      xrf_e[k].rt_index = rob_data[k].w_index;
      xrf_e[k].rt_data  = rob_data[k].w_data[XLEN-1:0];
    end

    csr_found = 1'b0;
    csr_pick  = '0;
    sat       = 1'b0;
    for (int k = 0; k < NU; k++) begin
      if (!csr_found && rob_data[k].w_valid && rob_data[k].trap_flag) begin
        csr_found = 1'b1;
        csr_pick  = rob_data[k].vector_csr;
      end
      if (live[k] && (act[k] & rob_data[k].vsaturate) != '0) begin
        sat = 1'b1;
      end
    end

    exp_vrf_data <= vrf_e;
    exp_xrf_data <= xrf_e;
    if (reset) begin
      exp_vrf_valid  <= '0;
      exp_xrf_valid  <= '0;
      exp_vcsr_valid <= 1'b0;
      exp_vcsr_data  <= '0;
      exp_vxsat      <= 1'b0;
    end else begin
      for (int k = 0; k < NU; k++) begin
        exp_vrf_valid[k] <= live[k] && !rob_data[k].w_type;
        exp_xrf_valid[k] <= live[k] && rob_data[k].w_type;
      end
      exp_vcsr_valid <= csr_found;
      exp_vcsr_data  <= csr_pick;
      exp_vxsat      <= sat;
    end
  end

  ////////////////////
  // checks

  a_reset_idle : assert property (@(posedge clk)
    $fell(reset) |-> (vrf_valid == '0 && xrf_valid == '0 && !vcsr_valid && !vxsat_set))
    else raise_error("outputs were not idle in the cycle after reset release");

  for (genvar k = 0; k < NU; k++) begin : g_lane_check
    a_vrf_valid : assert property (@(posedge clk) disable iff (reset)
      vrf_valid[k] == exp_vrf_valid[k])
      else value_mismatch($sformatf("vrf_valid[%0d]", k),
                          CW'($sampled(vrf_valid[k])), CW'($sampled(exp_vrf_valid[k])));
    a_xrf_valid : assert property (@(posedge clk) disable iff (reset)
      xrf_valid[k] == exp_xrf_valid[k])
      else value_mismatch($sformatf("xrf_valid[%0d]", k),
                          CW'($sampled(xrf_valid[k])), CW'($sampled(exp_xrf_valid[k])));
    // strobe follows the waw rule even on lanes that do not write
    a_strobe : assert property (@(posedge clk) disable iff (reset)
      vrf_data[k].rt_strobe == exp_vrf_data[k].rt_strobe)
      else value_mismatch($sformatf("vrf_data[%0d].rt_strobe", k),
                          CW'($sampled(vrf_data[k].rt_strobe)),
                          CW'($sampled(exp_vrf_data[k].rt_strobe)));
    a_vrf_index : assert property (@(posedge clk) disable iff (reset)
      exp_vrf_valid[k] |-> vrf_data[k].rt_index == exp_vrf_data[k].rt_index)
      else value_mismatch($sformatf("vrf_data[%0d].rt_index", k),
                          CW'($sampled(vrf_data[k].rt_index)),
                          CW'($sampled(exp_vrf_data[k].rt_index)));
    a_vrf_data : assert property (@(posedge clk) disable iff (reset)
      exp_vrf_valid[k] |-> vrf_data[k].rt_data == exp_vrf_data[k].rt_data)
      else value_mismatch($sformatf("vrf_data[%0d].rt_data", k),
                          CW'($sampled(vrf_data[k].rt_data)),
                          CW'($sampled(exp_vrf_data[k].rt_data)));
    a_xrf_index : assert property (@(posedge clk) disable iff (reset)
      exp_xrf_valid[k] |-> xrf_data[k].rt_index == exp_xrf_data[k].rt_index)
      else value_mismatch($sformatf("xrf_data[%0d].rt_index", k),
                          CW'($sampled(xrf_data[k].rt_index)),
                          CW'($sampled(exp_xrf_data[k].rt_index)));
    a_xrf_data : assert property (@(posedge clk) disable iff (reset)
      exp_xrf_valid[k] |-> xrf_data[k].rt_data == exp_xrf_data[k].rt_data)
      else value_mismatch($sformatf("xrf_data[%0d].rt_data", k),
                          CW'($sampled(xrf_data[k].rt_data)),
                          CW'($sampled(exp_xrf_data[k].rt_data)));
  end

  a_vcsr_valid : assert property (@(posedge clk) disable iff (reset)
    vcsr_valid == exp_vcsr_valid)
    else value_mismatch("vcsr_valid", CW'($sampled(vcsr_valid)), CW'($sampled(exp_vcsr_valid)));
  a_vcsr_data : assert property (@(posedge clk) disable iff (reset)
    vcsr_data == exp_vcsr_data)
    else value_mismatch("vcsr_data", CW'($sampled(vcsr_data)), CW'($sampled(exp_vcsr_data)));
  a_vxsat : assert property (@(posedge clk) disable iff (reset)
    vxsat_set == exp_vxsat)
    else value_mismatch("vxsat_set", CW'($sampled(vxsat_set)), CW'($sampled(exp_vxsat)));

  ////////////////////
  // run control

  initial begin : watchdog
    #(WATCHDOG_TIME);
    raise_error("watchdog expired before the test sequence finished");
  end

  initial begin : main
    logic [NU-1:0]    v;
    rob2rt_t [NU-1:0] d;
    clk         = 1'b0;
    reset       = 1'b1;
    rob_valid   = '0;
    rob_data    = '0;
    error_count = 0;
    void'($urandom(97));

    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    // a new group every cycle, no gaps
    for (int c = 0; c < TEST_CYCLES; c++) begin
      make_group(v, d);
      rob_valid <= v;
      rob_data  <= d;
      @(posedge clk);
    end
    rob_valid <= '0;
    rob_data  <= '0;
    repeat (3) @(posedge clk);
    @(negedge clk);  // let the last checks fire first

    if (error_count == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      raise_error("errors were counted during the run");
    end
  end

endmodule

// ==== list.f ====
+incdir+logic
logic/rt_uop_pkg.sv
logic/rt_wb_pkg.sv
logic/rt_hazard_scan.sv
logic/rt_lane_writeback.sv
logic/rt_csr_merge.sv
logic/rvv_retire.sv
dv/tb_rvv_retire.sv

// ==== logic/rt_config.svh ====
`ifndef RT_CONFIG_SVH
`define RT_CONFIG_SVH

////////////////////
// vector register geometry

// bits per vector register
`define RT_VLEN 128

// bytes per vector register, one strobe bit each
`define RT_VLENB (`RT_VLEN / 8)

////////////////////
// scalar side

`define RT_XLEN 32  // xrf width, low bits of w_data

// register index width, shared by vrf and xrf
`define RT_INDEX_W 5

////////////////////
// retire group

// uops per group, lane 0 oldest
`define RT_NUM_UOP 4

`endif

// ==== logic/rt_csr_merge.sv ====
`include "rt_config.svh"

module rt_csr_merge (
  input  logic                                  clk,
  input  logic                                  reset,
  input  rt_uop_pkg::rob2rt_t [`RT_NUM_UOP-1:0] rob_data,
  input  logic [`RT_NUM_UOP-1:0]                lane_vxsat,
  output logic                                  vcsr_valid,
  output rt_uop_pkg::vcsr_t                     vcsr_data,
  output logic                                  vxsat_set
);

  import rt_uop_pkg::*;

  logic  trap_hit;
  vcsr_t trap_csr;
  logic  sat_any;

  ////////////////////
  // oldest trapping lane

  // walk young to old so the oldest match is the one left
  always_comb begin
    trap_hit = 1'b0;
    trap_csr = '0;
    for (int k = `RT_NUM_UOP - 1; k >= 0; k--) begin
      if (rob_data[k].w_valid && rob_data[k].trap_flag) begin
        trap_hit = 1'b1;
        trap_csr = rob_data[k].vector_csr;
      end
    end
  end

  assign sat_any = |lane_vxsat;  // lanes already gate kill and tags

  ////////////////////
  // output registers

  always_ff @(posedge clk) begin
    if (reset) begin
      vcsr_valid <= 1'b0;
      vcsr_data  <= '0;
      vxsat_set  <= 1'b0;
    end else begin
      vcsr_valid <= trap_hit;
      vcsr_data  <= trap_csr;
      vxsat_set  <= sat_any;
    end
  end

  // csr bus stays quiet between traps
  a_csr_idle_zero : assert property (@(posedge clk) disable iff (reset)
    !vcsr_valid |-> (vcsr_data == '0))
    else $error("vcsr_data not zero while idle");

endmodule

// ==== logic/rt_hazard_scan.sv ====
`include "rt_config.svh"

module rt_hazard_scan (
  input  logic [`RT_NUM_UOP-1:0]                 rob_valid,
  input  rt_uop_pkg::rob2rt_t [`RT_NUM_UOP-1:0]  rob_data,
  output rt_wb_pkg::lane_ctrl_t [`RT_NUM_UOP-1:0] lane_ctrl
);

  import rt_uop_pkg::*;

  logic [`RT_NUM_UOP-1:0]                       in_run;    // lane belongs to the lane 0 run
  logic [`RT_NUM_UOP-1:0]                       kill;
  logic [`RT_NUM_UOP-1:0][`RT_VLENB-1:0]        byte_en;   // body active per byte
  logic [`RT_NUM_UOP-1:0][`RT_NUM_UOP-1:0]      same_idx;  // [older][younger]
  logic [`RT_NUM_UOP-1:0][`RT_VLENB-1:0]        overwrite;

  ////////////////////
  // destination run

  // run starts at lane 0 and stops at the first change of valid or type
  always_comb begin
    in_run[0] = 1'b1;
    for (int k = 1; k < `RT_NUM_UOP; k++) begin
      in_run[k] = in_run[k-1] &&
                  (rob_valid[k] == rob_valid[k-1]) &&
                  (rob_data[k].w_type == rob_data[k-1].w_type);
    end
  end

  ////////////////////
  // trap kill

  // any older trap kills, the older lane's valid is not looked at
  always_comb begin
    kill[0] = 1'b0;
    for (int k = 1; k < `RT_NUM_UOP; k++) begin
      kill[k] = kill[k-1] || rob_data[k-1].trap_flag;
    end
  end

  ////////////////////
  // waw byte masks

  always_comb begin
    for (int k = 0; k < `RT_NUM_UOP; k++) begin
      for (int b = 0; b < `RT_VLENB; b++) begin
        byte_en[k][b] = (rob_data[k].vd_type[b] == BODY_ACTIVE);
      end
    end
  end

  // index compare, only the upper triangle is read
  always_comb begin
    for (int k = 0; k < `RT_NUM_UOP; k++) begin
      for (int j = 0; j < `RT_NUM_UOP; j++) begin
        same_idx[k][j] = (rob_data[k].w_index == rob_data[j].w_index);
      end
    end
  end

  // younger same-run lanes on the same register take the byte
  // run is a prefix, so a younger run member implies the older one is in it
  always_comb begin
    for (int k = 0; k < `RT_NUM_UOP; k++) begin
      overwrite[k] = '0;
      for (int j = k + 1; j < `RT_NUM_UOP; j++) begin
        if (in_run[j] && same_idx[k][j]) begin
          overwrite[k] = overwrite[k] | byte_en[j];
        end
      end
    end
  end

  always_comb begin
    for (int k = 0; k < `RT_NUM_UOP; k++) begin
      lane_ctrl[k].kill      = kill[k];
      lane_ctrl[k].overwrite = overwrite[k];
    end
  end

  // oldest lane retires no matter what the rest of the group does
  always_comb begin
    a_lane0_alive : assert (!lane_ctrl[0].kill)
      else $error("lane 0 killed by its own group");
  end

endmodule

// ==== logic/rt_lane_writeback.sv ====
`include "rt_config.svh"

module rt_lane_writeback (
  input  logic                  clk,
  input  logic                  reset,
  input  rt_uop_pkg::rob2rt_t   uop,
  input  rt_wb_pkg::lane_ctrl_t ctrl,
  output logic                  vrf_valid,
  output logic                  xrf_valid,
  output rt_wb_pkg::rt2vrf_t    vrf_data,
  output rt_wb_pkg::rt2xrf_t    xrf_data,
  output logic                  vxsat
);

  import rt_uop_pkg::*;
  import rt_wb_pkg::*;

  logic [`RT_VLENB-1:0] byte_en;
  logic [`RT_VLENB-1:0] strobe;
  logic                 live;
  rt2vrf_t              vrf_next;
  rt2xrf_t              xrf_next;

  ////////////////////
  // byte enables and strobe

  always_comb begin
    for (int b = 0; b < `RT_VLENB; b++) begin
      byte_en[b] = (uop.vd_type[b] == BODY_ACTIVE);
    end
  end

  assign strobe = byte_en & ~ctrl.overwrite;  // younger lane wins

  assign live = uop.w_valid && !ctrl.kill;

  // saturation counts body-active bytes, waw does not hide it
  assign vxsat = live && |(byte_en & uop.vsaturate);

  ////////////////////
  // write records

  always_comb begin
    vrf_next.rt_index  = uop.w_index;
    vrf_next.rt_data   = uop.w_data;
    vrf_next.rt_strobe = strobe;
    xrf_next.rt_index  = uop.w_index;
    xrf_next.rt_data   = uop.w_data[`RT_XLEN-1:0];  // scalar result sits in the low bits
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      vrf_valid <= 1'b0;
      xrf_valid <= 1'b0;
    end else begin
      vrf_valid <= live && !uop.w_type;
      xrf_valid <= live && uop.w_type;
    end
  end

  always_ff @(posedge clk) begin
    vrf_data <= vrf_next;
    xrf_data <= xrf_next;
  end

  // one lane feeds exactly one register file
  a_one_target : assert property (@(posedge clk) disable iff (reset)
    !(vrf_valid && xrf_valid))
    else $error("lane writes vrf and xrf together");

endmodule

// ==== logic/rt_uop_pkg.sv ====
`include "rt_config.svh"

package rt_uop_pkg;

  ////////////////////
  // per-byte tag from the execution units

  typedef enum logic [1:0] {
    PRESTART      = 2'd0,
    BODY_INACTIVE = 2'd1,
    TAIL          = 2'd2,
    BODY_ACTIVE   = 2'd3  // the only tag that writes
  } byte_type_e;

  ////////////////////
  // vector csr snapshot carried with each uop

  typedef struct packed {
    logic [15:0] vl;
    logic [15:0] vstart;  // restart point after a trap
    logic [2:0]  vlmul;
    logic [2:0]  vsew;
    logic        vma;     // mask agnostic
    logic        vta;     // tail agnostic
  } vcsr_t;

  ////////////////////
  // one uop leaving the reorder buffer

  typedef struct packed {
    logic                           w_valid;    // uop writes a register
    logic                           w_type;     // 0 vrf, 1 xrf
    logic [`RT_INDEX_W-1:0]         w_index;
    logic [`RT_VLEN-1:0]            w_data;
    byte_type_e [`RT_VLENB-1:0]     vd_type;
    logic [`RT_VLENB-1:0]           vsaturate;  // per byte
    logic                           trap_flag;
    vcsr_t                          vector_csr;
  } rob2rt_t;

endpackage

// ==== logic/rt_wb_pkg.sv ====
`include "rt_config.svh"

package rt_wb_pkg;

  ////////////////////
  // vector register file write

  typedef struct packed {
    logic [`RT_INDEX_W-1:0] rt_index;
    logic [`RT_VLEN-1:0]    rt_data;
    logic [`RT_VLENB-1:0]   rt_strobe;  // byte enables after waw
  } rt2vrf_t;

  ////////////////////
  // scalar register file write

  typedef struct packed {
    logic [`RT_INDEX_W-1:0] rt_index;
    logic [`RT_XLEN-1:0]    rt_data;
  } rt2xrf_t;

  // scan result handed to one lane
  typedef struct packed {
    logic                 kill;       // an older lane trapped
    logic [`RT_VLENB-1:0] overwrite;  // bytes a younger lane will write
  } lane_ctrl_t;

endpackage

// ==== logic/rvv_retire.sv ====
`include "rt_config.svh"

module rvv_retire (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic [`RT_NUM_UOP-1:0]                 rob_valid,
  input  rt_uop_pkg::rob2rt_t [`RT_NUM_UOP-1:0]  rob_data,
  output logic [`RT_NUM_UOP-1:0]                 vrf_valid,
  output rt_wb_pkg::rt2vrf_t [`RT_NUM_UOP-1:0]   vrf_data,
  output logic [`RT_NUM_UOP-1:0]                 xrf_valid,
  output rt_wb_pkg::rt2xrf_t [`RT_NUM_UOP-1:0]   xrf_data,
  output logic                                   vcsr_valid,
  output rt_uop_pkg::vcsr_t                      vcsr_data,
  output logic                                   vxsat_set
);

  import rt_wb_pkg::*;

  lane_ctrl_t [`RT_NUM_UOP-1:0] lane_ctrl;
  logic [`RT_NUM_UOP-1:0]       lane_vxsat;  // per lane, before the merge register

  ////////////////////
  // group scan, combinational

  rt_hazard_scan u_scan (
    .rob_valid (rob_valid),
    .rob_data  (rob_data),
    .lane_ctrl (lane_ctrl)
  );

  ////////////////////
  // lanes

  for (genvar k = 0; k < `RT_NUM_UOP; k++) begin : g_lane
    rt_lane_writeback u_lane (
      .clk       (clk),
      .reset     (reset),
      .uop       (rob_data[k]),
      .ctrl      (lane_ctrl[k]),
      .vrf_valid (vrf_valid[k]),
      .xrf_valid (xrf_valid[k]),
      .vrf_data  (vrf_data[k]),
      .xrf_data  (xrf_data[k]),
      .vxsat     (lane_vxsat[k])
    );
  end

  // csr and saturation
  rt_csr_merge u_merge (
    .clk        (clk),
    .reset      (reset),
    .rob_data   (rob_data),
    .lane_vxsat (lane_vxsat),
    .vcsr_valid (vcsr_valid),
    .vcsr_data  (vcsr_data),
    .vxsat_set  (vxsat_set)
  );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the retire stage testbench with verilator

cd "$(dirname "$0")" || exit 1
mkdir -p build

verilator --binary --timing --assert -Mdir build --top-module tb_rvv_retire -f list.f \
  > build/compile.log 2>&1 || { cat build/compile.log; exit 1; }

./build/Vtb_rvv_retire > build/sim.log 2>&1
cat build/sim.log

grep -q -x "All tests passed" build/sim.log && exit 0 || exit 1
